// File: bench/rvCoreProgram.svh
function automatic wordT encR(input logic [6:0] f7, input logic [4:0] rs2,
                              input logic [4:0] rs1, input logic [2:0] f3,
                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opOp};
endfunction

function automatic wordT encI(input logic [31:0] imm, input logic [4:0] rs1,
                              input logic [2:0] f3, input logic [4:0] rd,
                              input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic wordT encS(input logic [31:0] imm, input logic [4:0] rs2,
                              input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
endfunction

function automatic wordT encB(input logic [31:0] imm, input logic [4:0] rs2,
                              input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic wordT encU(input logic [19:0] imm, input logic [4:0] rd,
                              input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic wordT encJ(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

// Program word at instruction index idx and byte address idx*4
function automatic wordT programWord(input int idx);
    case (idx)
        0:  return encI(-5, 0, f3AddSub, 1, opOpImm);
        1:  return encI(12, 0, f3AddSub, 2, opOpImm);
        2:  return encR(7'h00, 2, 1, f3AddSub, 3);
        3:  return encR(7'h20, 2, 1, f3AddSub, 4);   // sub
        4:  return encR(7'h00, 2, 1, f3And, 5);
        5:  return encR(7'h00, 2, 1, f3Or, 6);
        6:  return encR(7'h00, 2, 1, f3Xor, 7);
        7:  return encR(7'h00, 2, 1, f3Slt, 8);
        8:  return encR(7'h00, 2, 1, f3Sltu, 9);
        9:  return encR(7'h00, 1, 2, f3Sltu, 10);
        10: return encR(7'h00, 2, 1, f3Sll, 11);
        11: return encR(7'h00, 2, 1, f3SrlSra, 12);
        12: return encR(7'h20, 2, 1, f3SrlSra, 13);  // sra
        13: return encI(28, 2, f3Sll, 14, opOpImm);
        14: return encI(4, 14, f3SrlSra, 15, opOpImm);
        15: return encI(12'h404, 14, f3SrlSra, 16, opOpImm);   // srai
        16: return encU(20'h12345, 17, opLui);
        17: return encU(20'h00001, 18, opAuipc);
        18: return encU(20'hFFFFF, 19, opLui);
        19: return encB(8, 1, 1, f3Beq);
        21: return encB(8, 2, 1, f3Beq);
        22: return encB(8, 2, 1, f3Bne);
        24: return encB(8, 1, 1, f3Bne);
        25: return encB(8, 2, 1, f3Blt);
        27: return encB(8, 1, 2, f3Blt);
        28: return encB(8, 1, 2, f3Bge);
        30: return encB(8, 2, 1, f3Bge);
        31: return encB(8, 1, 2, f3Bltu);
        33: return encB(8, 2, 1, f3Bltu);
        34: return encB(8, 2, 1, f3Bgeu);
        36: return encB(8, 1, 2, f3Bgeu);
        37: return encJ(12, 20);
        39: return encI(13, 20, 3'b000, 21, opJalr);   // Odd target with bit 0 cleared
        40: return encB(-4, 0, 0, f3Beq);              // Backward branch
        20, 23, 26, 29, 32, 35, 38: return encI(1, 0, f3AddSub, 31, opOpImm);
        41: return encU(20'h87654, 22, opLui);
        42: return encI(12'h321, 22, f3AddSub, 22, opOpImm);
        43: return encS(256, 22, 0, f3Word);
        44: return encI(244, 2, f3Word, 23, opLoad);
        45: return encS(256, 1, 0, f3Half);
        46: return encS(258, 2, 0, f3Byte);
        47: return encI(256, 0, f3Word, 24, opLoad);
        48: return encI(256, 0, f3Byte, 25, opLoad);
        49: return encI(257, 0, f3ByteU, 26, opLoad);
        50: return encI(258, 0, f3Byte, 27, opLoad);
        51: return encI(259, 0, f3ByteU, 28, opLoad);
        52: return encI(259, 0, f3Byte, 29, opLoad);
        53: return encI(256, 0, f3Half, 30, opLoad);
        54: return encI(256, 0, f3HalfU, 31, opLoad);
        55: return encI(258, 0, f3Half, 30, opLoad);
        56: return encI(258, 0, f3HalfU, 31, opLoad);
        57: return encI(5, 0, f3AddSub, 0, opOpImm);   // Write to x0
        58: return encR(7'h00, 0, 0, f3AddSub, 3);
        59: return 32'hFFFFFFFF;
        60: return 32'h00000000;
        61: return encI(1, 0, f3AddSub, 4, opOpImm);
        default: return encJ(0, 0);   // Jump to self
    endcase
endfunction

localparam int numSteps  = 55;
localparam int numWbs    = 36;
localparam int numGroups = 5;

int     expStep [numSteps];   // Instruction index fetched at each step
regIdxT expRd [numWbs];
wordT   expData [numWbs];
string  groupName [numGroups];
int     groupLast [numGroups];
int     groupWbEnd [numGroups];

initial begin
    expStep = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 18,
                19, 21, 22, 24, 25, 27, 28, 30, 31, 33, 34, 36, 37, 40, 39,
                41, 42, 43, 44, 45, 46, 47, 48, 49, 50, 51, 52, 53, 54, 55, 56,
                57, 58, 59, 60, 61};
    expRd = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16,
              17, 18, 19,
              20, 21,
              22, 22, 23, 24, 25, 26, 27, 28, 29, 30, 31, 30, 31,
              3, 4};
    expData = '{32'hFFFFFFFB, 32'h0000000C, 32'h00000007, 32'hFFFFFFEF,
                32'h00000008, 32'hFFFFFFFF, 32'hFFFFFFF7, 32'h00000001,
                32'h00000000, 32'h00000001, 32'hFFFFB000, 32'h000FFFFF,
                32'hFFFFFFFF, 32'hC0000000, 32'h0C000000, 32'hFC000000,
                32'h12345000, 32'h00001044, 32'hFFFFF000,
                32'h00000098, 32'h000000A0,
                32'h87654000, 32'h87654321, 32'h87654321, 32'h870CFFFB,
                32'hFFFFFFFB, 32'h000000FF, 32'h0000000C, 32'h00000087,
                32'hFFFFFF87, 32'hFFFFFFFB, 32'h0000FFFB, 32'hFFFF870C,
                32'h0000870C,
                32'h00000000, 32'h00000001};
    groupName  = '{"arithmetic and logic", "upper immediates", "control flow",
                   "memory", "x0 and unknown opcodes"};
    groupLast  = '{15, 18, 33, 49, 54};
    groupWbEnd = '{16, 19, 21, 34, 36};
end

// File: bench/rvCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module rvCoreTb;
    import rvCorePkg::*;
    import rvIsaPkg::*;

    localparam int resetCycles = 5;
    localparam int maxCycles   = 200;   // About 60 instructions plus reset and a margin

    logic   CLK;
    logic   RESET;
    wordT   fetchAddr;
    wordT   fetchInstr;
    logic   wbValid;
    regIdxT wbAddr;
    wordT   wbData;

    `include "rvCoreProgram.svh"

    int stepIdx     = 0;
    int wbIdx       = 0;
    int groupIdx    = 0;
    int groupErrors = 0;
    int checks      = 0;
    int errors      = 0;
    int cycles      = 0;
    bit done        = 1'b0;

    rvCore rvCore_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .fetchAddr  (fetchAddr),
        .fetchInstr (fetchInstr),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

    assign fetchInstr = programWord(int'(fetchAddr[31:2]));   // Fetch answers same cycle

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
    end

    task automatic reportGroup();
        if (wbIdx != groupWbEnd[groupIdx]) begin
            errors++;
            $display("Group %s expected %0d writebacks in total by its end, saw %0d",
                     groupName[groupIdx], groupWbEnd[groupIdx], wbIdx);
        end
        $display("%s: done at step %0d, %0d errors", groupName[groupIdx], stepIdx,
                 errors - groupErrors);
        groupErrors = errors;
        groupIdx++;
    endtask

    always @(posedge CLK) begin
        if (RESET) begin
            checks++;
            assert (!wbValid) else begin
                errors++;
                $display("MISMATCH at %0t: wbValid high during reset", $time);
            end
        end else if (!done) begin
            if (wbValid) begin
                if (wbIdx >= numWbs) begin
                    errors++;
                    $display("Extra writeback to x%0d after the last expected one", wbAddr);
                end else begin
                    checks++;
                    assert (wbAddr == expRd[wbIdx] && wbData == expData[wbIdx]) else begin
                        errors++;
                        $display("MISMATCH at %0t: wb %0d expected x%0d = %h, got x%0d = %h",
                                 $time, wbIdx, expRd[wbIdx], expData[wbIdx], wbAddr, wbData);
                    end
                    wbIdx++;
                end
            end
            checks++;
            assert (fetchAddr == wordT'(expStep[stepIdx] * 4)) else begin
                errors++;
                $display("MISMATCH at %0t: step %0d expected fetchAddr %h, got %h",
                         $time, stepIdx, expStep[stepIdx] * 4, fetchAddr);
            end
            if (stepIdx == groupLast[groupIdx]) begin
                reportGroup();
            end
            stepIdx++;
            done = (stepIdx == numSteps);
        end
    end

    initial begin
        RESET = 1'b1;
        repeat (resetCycles) @(negedge CLK);
        RESET = 1'b0;
        $display("reset: wbValid held low for %0d cycles, %0d errors", resetCycles, errors);
        groupErrors = errors;
        wait (done || cycles >= maxCycles);
        if (!done) begin
            errors++;
            $display("Timeout: run stopped after %0d cycles with step %0d of %0d reached",
                     cycles, stepIdx, numSteps);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  rvCorePkg::wordT  in1,
    input  rvCorePkg::wordT  in2,
    input  rvCorePkg::aluOpT aluOp,
    output rvCorePkg::wordT  result
);
    import rvCorePkg::*;

    localparam int shamtW = $clog2(xlen);

    logic [shamtW-1:0] shamt;

    assign shamt = in2[shamtW-1:0];

    always_comb begin
        case (aluOp)
            aluAdd:   result = in1 + in2;
            aluSub:   result = in1 - in2;
            aluAnd:   result = in1 & in2;
            aluOr:    result = in1 | in2;
            aluXor:   result = in1 ^ in2;
            aluSlt:   result = wordT'($signed(in1) < $signed(in2));
            aluSltu:  result = wordT'(in1 < in2);
            aluSll:   result = in1 << shamt;
            aluSrl:   result = in1 >> shamt;
            aluSra:   result = wordT'($signed(in1) >>> shamt);
            aluCopy1: result = in1;
            aluCopy2: result = in2;   // LUI immediate
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/dataMemory.sv
`timescale 1ns/1ns
`default_nettype none

module dataMemory (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             memRead,
    input  logic             memWrite,
    input  rvIsaPkg::funct3T funct3,
    input  rvCorePkg::wordT  addr,
    input  rvCorePkg::wordT  writeData,
    output rvCorePkg::wordT  readData
);
    import rvCorePkg::*;
    import rvIsaPkg::*;

    localparam int offW = $clog2(xlen / 8);
    localparam int idxW = $clog2(dmemWords);

    wordT mem [dmemWords];

    logic [idxW-1:0] wordIdx;
    logic [offW-1:0] byteOff;
    wordT            word;
    wordT            merged;
    logic [7:0]      byteSel;
    logic [15:0]     halfSel;
    wordT            loadValue;

    assign wordIdx = addr[offW +: idxW];   // Wraps at the memory depth
    assign byteOff = addr[offW-1:0];
    assign word    = mem[wordIdx];

    always_comb begin
        merged = word;
        case (funct3)
            f3Byte:  merged[{byteOff, 3'b000} +: 8] = writeData[7:0];
            f3Half:  merged[{byteOff[1], 4'b0000} +: 16] = writeData[15:0];
            f3Word:  merged = writeData;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < dmemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite) begin
            mem[wordIdx] <= merged;
        end
    end

    assign byteSel = word[{byteOff, 3'b000} +: 8];
    assign halfSel = word[{byteOff[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3)
            f3Byte:  loadValue = {{(xlen-8){byteSel[7]}}, byteSel};
            f3Half:  loadValue = {{(xlen-16){halfSel[15]}}, halfSel};
            f3Word:  loadValue = word;
            f3ByteU: loadValue = {{(xlen-8){1'b0}}, byteSel};
            f3HalfU: loadValue = {{(xlen-16){1'b0}}, halfSel};
            default: loadValue = '0;
        endcase
    end

    assign readData = memRead ? loadValue : '0;

endmodule

`default_nettype wire

// File: verilog/immGen.sv
`timescale 1ns/1ns
`default_nettype none

module immGen (
    input  rvCorePkg::wordT  instr,
    input  rvIsaPkg::immFmtT immFmt,
    output rvCorePkg::wordT  imm
);
    import rvCorePkg::*;
    import rvIsaPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immFmt)
            fmtI: imm = {{(xlen-12){sign}}, instr[31:20]};
            fmtS: imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            fmtB: begin
                imm = {{(xlen-13){sign}}, sign, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            fmtU: imm = {instr[31:12], 12'b0};   // Low bits always zero
            fmtJ: begin
                imm = {{(xlen-21){sign}}, sign, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/nextPcUnit.sv
`timescale 1ns/1ns
`default_nettype none

module nextPcUnit (
    input  rvCorePkg::wordT  pc,
    input  rvCorePkg::wordT  rs1Data,
    input  rvCorePkg::wordT  rs2Data,
    input  rvCorePkg::wordT  imm,
    input  rvIsaPkg::funct3T funct3,
    input  logic             jump,
    input  logic             jumpReg,
    input  logic             branch,
    output rvCorePkg::wordT  nextPc
);
    import rvCorePkg::*;
    import rvIsaPkg::*;

    logic equal;
    logic lessSigned;
    logic lessUnsigned;
    logic condition;
    logic taken;
    wordT relTarget;

    assign equal        = rs1Data == rs2Data;
    assign lessSigned   = $signed(rs1Data) < $signed(rs2Data);
    assign lessUnsigned = rs1Data < rs2Data;

    always_comb begin
        case (funct3)
            f3Beq:   condition = equal;
            f3Bne:   condition = !equal;
            f3Blt:   condition = lessSigned;
            f3Bge:   condition = !lessSigned;
            f3Bltu:  condition = lessUnsigned;
            f3Bgeu:  condition = !lessUnsigned;
            default: condition = 1'b0;
        endcase
    end

    assign taken     = branch && condition;
    assign relTarget = pc + imm;   // Shared by JAL and branches

    always_comb begin
        if (jump) begin
            nextPc = relTarget;
        end else if (jumpReg) begin
            nextPc = (rs1Data + imm) & ~wordT'(1);
        end else if (taken) begin
            nextPc = relTarget;
        end else begin
            nextPc = pc + pcStep;
        end
    end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              writeEn,
    input  rvCorePkg::regIdxT rs1Addr,
    input  rvCorePkg::regIdxT rs2Addr,
    input  rvCorePkg::regIdxT rdAddr,
    input  rvCorePkg::wordT   rdData,
    output rvCorePkg::wordT   rs1Data,
    output rvCorePkg::wordT   rs2Data
);
    import rvCorePkg::*;

    localparam int numRegs = 2 ** regIdxW;

    wordT regs [1:numRegs-1];   // x0 has no storage

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 1; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rdAddr != '0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// File: verilog/rvCore.sv
`timescale 1ns/1ns
`default_nettype none

module rvCore (
    input  logic              CLK,
    input  logic              RESET,
    output rvCorePkg::wordT   fetchAddr,
    input  rvCorePkg::wordT   fetchInstr,
    output logic              wbValid,
    output rvCorePkg::regIdxT wbAddr,
    output rvCorePkg::wordT   wbData
);
    import rvCorePkg::*;
    import rvIsaPkg::*;

    wordT    pc;
    wordT    pcPlus;
    wordT    nextPc;
    regIdxT  rs1Addr;
    regIdxT  rs2Addr;
    regIdxT  rdAddr;
    funct3T  funct3;
    immFmtT  immFmt;
    aluOpT   aluOp;
    src1SelT src1Sel;
    src2SelT src2Sel;
    wbSelT   wbSel;
    logic    jump;
    logic    jumpReg;
    logic    branch;
    logic    memRead;
    logic    memWrite;
    logic    regWrite;
    wordT    imm;
    wordT    rs1Data;
    wordT    rs2Data;
    wordT    aluIn1;
    wordT    aluIn2;
    wordT    aluResult;
    wordT    loadData;
    wordT    wbValue;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc <= resetVector;
        end else begin
            pc <= nextPc;
        end
    end

    assign fetchAddr = pc;
    assign pcPlus    = pc + pcStep;   // Link address

    assign rs1Addr = fetchInstr[rs1Lsb +: regIdxW];
    assign rs2Addr = fetchInstr[rs2Lsb +: regIdxW];
    assign rdAddr  = fetchInstr[rdLsb +: regIdxW];
    assign funct3  = fetchInstr[funct3Lsb +: $bits(funct3T)];

    rvDecoder rvDecoder_i (
        .instr    (fetchInstr),
        .immFmt   (immFmt),
        .aluOp    (aluOp),
        .src1Sel  (src1Sel),
        .src2Sel  (src2Sel),
        .jump     (jump),
        .jumpReg  (jumpReg),
        .branch   (branch),
        .memRead  (memRead),
        .memWrite (memWrite),
        .regWrite (regWrite),
        .wbSel    (wbSel)
    );

    immGen immGen_i (
        .instr  (fetchInstr),
        .immFmt (immFmt),
        .imm    (imm)
    );

    regFile regFile_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .writeEn (regWrite),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (rdAddr),
        .rdData  (wbValue),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign aluIn1 = (src1Sel == src1Pc) ? pc : rs1Data;
    assign aluIn2 = (src2Sel == src2Imm) ? imm : rs2Data;

    alu alu_i (
        .in1    (aluIn1),
        .in2    (aluIn2),
        .aluOp  (aluOp),
        .result (aluResult)
    );

    nextPcUnit nextPcUnit_i (
        .pc      (pc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .imm     (imm),
        .funct3  (funct3),
        .jump    (jump),
        .jumpReg (jumpReg),
        .branch  (branch),
        .nextPc  (nextPc)
    );

    dataMemory dataMemory_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .funct3    (funct3),
        .addr      (aluResult),
        .writeData (rs2Data),
        .readData  (loadData)
    );

    always_comb begin
        case (wbSel)
            wbMem:   wbValue = loadData;
            wbLink:  wbValue = pcPlus;
            default: wbValue = aluResult;
        endcase
    end

    // Trace of the write that lands at the next edge
    assign wbValid = regWrite && rdAddr != '0 && !RESET;
    assign wbAddr  = rdAddr;
    assign wbData  = wbValue;

endmodule

`default_nettype wire

// File: verilog/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    localparam int xlen = 32;
    typedef logic [xlen-1:0] wordT;

    localparam int regIdxW = 5;
    typedef logic [regIdxW-1:0] regIdxT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluCopy1,
        aluCopy2
    } aluOpT;

    typedef enum logic {src1Rs1, src1Pc} src1SelT;
    typedef enum logic {src2Rs2, src2Imm} src2SelT;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbLink   // PC plus 4 for JAL and JALR
    } wbSelT;

    localparam int   dmemWords   = 512;
    localparam wordT resetVector = '0;
    localparam wordT pcStep      = 32'd4;

endpackage

`default_nettype wire

// File: verilog/rvDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module rvDecoder (
    input  rvCorePkg::wordT    instr,
    output rvIsaPkg::immFmtT   immFmt,
    output rvCorePkg::aluOpT   aluOp,
    output rvCorePkg::src1SelT src1Sel,
    output rvCorePkg::src2SelT src2Sel,
    output logic               jump,
    output logic               jumpReg,
    output logic               branch,
    output logic               memRead,
    output logic               memWrite,
    output logic               regWrite,
    output rvCorePkg::wbSelT   wbSel
);
    import rvCorePkg::*;
    import rvIsaPkg::*;

    opcodeT opcode;
    funct3T funct3;
    logic   alt;
    logic   altLegal;

    assign opcode = opcodeT'(instr[$bits(opcodeT)-1:0]);
    assign funct3 = instr[funct3Lsb +: $bits(funct3T)];
    assign alt    = instr[altBit];

    // Bit 30 is immediate data for I-type, except on the shifts
    assign altLegal = !alt || funct3 == f3SrlSra ||
                      (opcode == opOp ? funct3 == f3AddSub : funct3 != f3Sll);

    always_comb begin
        immFmt   = fmtNone;
        aluOp    = aluAdd;
        src1Sel  = src1Rs1;
        src2Sel  = src2Rs2;
        jump     = 1'b0;
        jumpReg  = 1'b0;
        branch   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        wbSel    = wbAlu;

        case (opcode)
            opLui: begin
                immFmt   = fmtU;
                aluOp    = aluCopy2;
                src2Sel  = src2Imm;
                regWrite = 1'b1;
            end
            opAuipc: begin
                immFmt   = fmtU;
                src1Sel  = src1Pc;
                src2Sel  = src2Imm;
                regWrite = 1'b1;
            end
            opJal: begin
                immFmt   = fmtJ;
                jump     = 1'b1;
                regWrite = 1'b1;
                wbSel    = wbLink;
            end
            opJalr: begin
                if (funct3 == '0) begin
                    immFmt   = fmtI;
                    jumpReg  = 1'b1;
                    regWrite = 1'b1;
                    wbSel    = wbLink;
                end
            end
            opBranch: begin
                if (funct3 inside {f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu}) begin
                    immFmt = fmtB;
                    branch = 1'b1;
                end
            end
            opLoad: begin
                if (funct3 inside {f3Byte, f3Half, f3Word, f3ByteU, f3HalfU}) begin
                    immFmt   = fmtI;
                    src2Sel  = src2Imm;
                    memRead  = 1'b1;
                    regWrite = 1'b1;
                    wbSel    = wbMem;
                end
            end
            opStore: begin
                if (funct3 inside {f3Byte, f3Half, f3Word}) begin
                    immFmt   = fmtS;
                    src2Sel  = src2Imm;
                    memWrite = 1'b1;
                end
            end
            opOpImm, opOp: begin
                if (altLegal) begin
                    regWrite = 1'b1;
                    if (opcode == opOpImm) begin
                        immFmt  = fmtI;
                        src2Sel = src2Imm;
                    end
                    case (funct3)
                        f3AddSub: aluOp = (opcode == opOp && alt) ? aluSub : aluAdd;
                        f3Sll:    aluOp = aluSll;
                        f3Slt:    aluOp = aluSlt;
                        f3Sltu:   aluOp = aluSltu;
                        f3Xor:    aluOp = aluXor;
                        f3SrlSra: aluOp = alt ? aluSra : aluSrl;
                        f3Or:     aluOp = aluOr;
                        default:  aluOp = aluAnd;
                    endcase
                end
            end
            default: ;   // Unknown opcode retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011
    } opcodeT;

    // Codes overlap between instruction classes
    typedef logic [2:0] funct3T;

    localparam funct3T f3Beq    = 3'b000;
    localparam funct3T f3Bne    = 3'b001;
    localparam funct3T f3Blt    = 3'b100;
    localparam funct3T f3Bge    = 3'b101;
    localparam funct3T f3Bltu   = 3'b110;
    localparam funct3T f3Bgeu   = 3'b111;

    localparam funct3T f3Byte   = 3'b000;
    localparam funct3T f3Half   = 3'b001;
    localparam funct3T f3Word   = 3'b010;
    localparam funct3T f3ByteU  = 3'b100;
    localparam funct3T f3HalfU  = 3'b101;

    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3SrlSra = 3'b101;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    typedef enum logic [2:0] {
        fmtNone,
        fmtI,
        fmtS,
        fmtB,
        fmtU,
        fmtJ
    } immFmtT;

    localparam int rdLsb     = 7;
    localparam int funct3Lsb = 12;
    localparam int rs1Lsb    = 15;
    localparam int rs2Lsb    = 20;
    localparam int altBit    = 30;   // Selects SUB and SRA

endpackage

`default_nettype wire

// File: vlog.f
+incdir+bench
verilog/rvIsaPkg.sv
verilog/rvCorePkg.sv
verilog/rvDecoder.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/alu.sv
verilog/nextPcUnit.sv
verilog/dataMemory.sv
verilog/rvCore.sv
bench/rvCoreTb.sv
